// ==== filelist.f ====
+incdir+source
source/alu_pkg.sv
source/simple_alu.sv
source/phys_regfile.sv
source/exec_pipeline.sv
source/simple_alu_lane_top.sv
verif/tb_simple_alu_lane.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the execute lane testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_simple_alu_lane

verilator --binary --timing --timescale 1ns/1ps \
    -f filelist.f --top-module "$TOP" -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verif/tb_simple_alu_lane.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the integer execute lane
// seeded random issue stream, reference model with a shadow
// register file, writeback checks and a watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module tb_simple_alu_lane;

    localparam int N_RAND       = 40;       // random instructions per section
    localparam int N_CHAIN      = 40;
    localparam int N_DIRECTED   = 40;       // margin for directed and idle cycles
    localparam int TOTAL_CYCLES = 10 + 62 + 4 * N_RAND + N_CHAIN + N_DIRECTED;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 50) * 100;

    logic                              clk;
    logic                              rst_n;
    logic                              issue_valid;
    logic [`SIZE_OPCODE_I-1:0]         opcode;
    logic [`SIZE_PHYSICAL_LOG-1:0]     src1;
    logic [`SIZE_PHYSICAL_LOG-1:0]     src2;
    logic [`SIZE_PHYSICAL_LOG-1:0]     dest;
    alu_pkg::immd_t                    immd;
    logic                              wb_valid;
    logic [`SIZE_PHYSICAL_LOG-1:0]     wb_dest;
    logic [`SIZE_DATA-1:0]             wb_result;
    logic [`EXECUTION_FLAGS-1:0]       wb_flags;

    logic [`SIZE_DATA-1:0]             shadow [`PHYS_REGS];     // model register file
    logic                              exp_valid  [$];
    logic [`SIZE_PHYSICAL_LOG-1:0]     exp_dest   [$];
    logic [`SIZE_DATA-1:0]             exp_result [$];
    logic [`EXECUTION_FLAGS-1:0]       exp_flags  [$];
    string                             exp_name   [$];
    logic [`SIZE_OPCODE_I-1:0]         op_pool    [$];
    logic [`SIZE_PHYSICAL_LOG-1:0]     last_dest;
    string                             test_name;
    int                                error_count;
    int                                check_count;

    simple_alu_lane_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .issue_valid_i (issue_valid),
        .opcode_i      (opcode),
        .src1_i        (src1),
        .src2_i        (src2),
        .dest_i        (dest),
        .immd_i        (immd),
        .wb_valid_o    (wb_valid),
        .wb_dest_o     (wb_dest),
        .wb_result_o   (wb_result),
        .wb_flags_o    (wb_flags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    task automatic alu_model(input logic [5:0] op, input logic [31:0] a, input logic [31:0] b,
                             input alu_pkg::immd_t im, output logic [31:0] res,
                             output logic [5:0] flg);
        logic [31:0] sext;
        logic [31:0] zext;
        longint      wide;
        logic        legal;
        logic        wr;
        logic        ovf;

        legal = 1'b1;
        wr    = 1'b1;
        ovf   = 1'b0;
        res   = 32'h0;
        sext  = {{16{im.imm[15]}}, im.imm};
        zext  = {16'h0000, im.imm};
        case (op)
            `ADD, `ADDU: begin
                wide = longint'($signed(a)) + longint'($signed(b));
                res  = wide[31:0];
                ovf  = (op == `ADD) && (wide != longint'($signed(res)));    // does not fit 32 bits
            end
            `ADDI, `ADDIU: begin
                wide = longint'($signed(a)) + longint'($signed(sext));
                res  = wide[31:0];
                ovf  = (op == `ADDI) && (wide != longint'($signed(res)));
            end
            `SUB, `SUBU: begin
                wide = longint'($signed(a)) - longint'($signed(b));
                res  = wide[31:0];
                ovf  = (op == `SUB) && (wide != longint'($signed(res)));
            end
            `AND:   res = a & b;
            `OR:    res = a | b;
            `XOR:   res = a ^ b;
            `NOR:   res = ~(a | b);
            `ANDI:  res = a & zext;
            `ORI:   res = a | zext;
            `XORI:  res = a ^ zext;
            `LUI:   res = {im.imm, 16'h0000};
            `SLL:   res = a << im.rfmt.shamt;
            `SRL:   res = a >> im.rfmt.shamt;
            `SRA:   res = $signed(a) >>> im.rfmt.shamt;
            `SLLV:  res = b << a[4:0];
            `SRLV:  res = b >> a[4:0];
            `SRAV:  res = $signed(b) >>> a[4:0];
            `SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            `SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            `SLTIU: res = (a < zext) ? 32'd1 : 32'd0;
            `NOP:   wr = 1'b0;
            default: begin
                legal = 1'b0;
                wr    = 1'b0;
            end
        endcase
        flg                      = 6'h00;
        flg[`FLAG_WRITE_BIT]     = wr & ~ovf;
        flg[`FLAG_EXECUTED_BIT]  = legal;
        flg[`FLAG_EXCEPTION_BIT] = ovf;
    endtask

    function automatic logic [4:0] rand_tag();
        logic [31:0] r;

        r = $urandom();
        return r[4:0];
    endfunction

    function automatic alu_pkg::immd_t make_imm(input logic [15:0] v);
        alu_pkg::immd_t u;

        u.imm = v;
        return u;
    endfunction

    function automatic alu_pkg::immd_t rand_imm();
        logic [31:0] r;

        r = $urandom();
        return make_imm(r[15:0]);   // shamt field random as well
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expv, input logic [31:0] actv);
        error_count++;
        $display("** Error %s %s: expected %h, actual %h", name, field, expv, actv);
    endtask

    task automatic check_writeback();
        logic                        ev;
        logic [4:0]                  ed;
        logic [31:0]                 er;
        logic [5:0]                  ef;
        string                       en;

        ev = exp_valid.pop_front();
        ed = exp_dest.pop_front();
        er = exp_result.pop_front();
        ef = exp_flags.pop_front();
        en = exp_name.pop_front();
        check_count++;
        if (wb_valid !== ev) report_mismatch(en, "wb_valid", 32'(ev), 32'(wb_valid));
        if (ev && (wb_dest !== ed)) report_mismatch(en, "wb_dest", 32'(ed), 32'(wb_dest));
        if (ev && (wb_result !== er)) report_mismatch(en, "wb_result", er, wb_result);
        if (ev && (wb_flags !== ef)) report_mismatch(en, "wb_flags", 32'(ef), 32'(wb_flags));
    endtask

    // checks the writeback of two cycles ago and then issues one instruction
    task automatic step(input logic v, input logic [5:0] op, input logic [4:0] s1,
                        input logic [4:0] s2, input logic [4:0] d, input alu_pkg::immd_t im);
        logic [31:0] res;
        logic [5:0]  flg;

        @(posedge clk);
        #10;
        check_writeback();
        issue_valid = v;
        opcode      = op;
        src1        = s1;
        src2        = s2;
        dest        = d;
        immd        = im;
        res         = 32'h0;
        flg         = 6'h00;
        if (v) begin
            alu_model(op, shadow[s1], shadow[s2], im, res, flg);
            if (flg[`FLAG_WRITE_BIT] && (d != 5'd0)) shadow[d] = res;
            last_dest = d;
        end
        exp_valid.push_back(v);
        exp_dest.push_back(d);
        exp_result.push_back(res);
        exp_flags.push_back(flg);
        exp_name.push_back(test_name);
    endtask

    task automatic idle();
        step(1'b0, `LUI, 5'd0, 5'd0, 5'd5, make_imm(16'hdead));  // dropped while valid is low
    endtask

    task automatic run_random(input int count, input logic chained);
        int         idx;
        logic [4:0] s1;

        for (int n = 0; n < count; n++) begin
            idx = $urandom_range(op_pool.size() - 1, 0);
            s1  = chained ? last_dest : rand_tag();     // chained reads the previous result
            step(1'b1, op_pool[idx], s1, rand_tag(), rand_tag(), rand_imm());
        end
    endtask

    initial begin
        logic [31:0] r;

        void'($urandom(58812));
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        opcode      = `NOP;
        src1        = 5'd0;
        src2        = 5'd0;
        dest        = 5'd0;
        immd        = make_imm(16'h0000);
        last_dest   = 5'd0;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < `PHYS_REGS; i++) shadow[i] = 32'h0;
        repeat (2) begin                                // pipeline is empty after reset
            exp_valid.push_back(1'b0);
            exp_dest.push_back(5'd0);
            exp_result.push_back(32'h0);
            exp_flags.push_back(6'h00);
            exp_name.push_back("reset");
        end
        repeat (10) @(posedge clk);
        #10 rst_n = 1'b1;

        test_name = "reset";
        repeat (3) idle();
        step(1'b1, `ADDU, 5'd5, 5'd6, 5'd7, make_imm(16'h0000));

        test_name = "seed_regs";
        for (int t = 1; t < 32; t++) begin
            r = $urandom();
            step(1'b1, `LUI, 5'd0, 5'd0, 5'(t), make_imm(r[31:16]));
            step(1'b1, `ORI, 5'(t), 5'd0, 5'(t), make_imm(r[15:0]));
        end

        test_name = "arith";
        op_pool = {`ADD, `ADDI, `ADDU, `ADDIU, `SUB, `SUBU};
        run_random(N_RAND, 1'b0);
        step(1'b1, `LUI, 5'd0, 5'd0, 5'd10, make_imm(16'h7fff));
        step(1'b1, `ORI, 5'd10, 5'd0, 5'd10, make_imm(16'hffff));
        step(1'b1, `ADD, 5'd10, 5'd10, 5'd11, make_imm(16'h0000));    // overflows
        step(1'b1, `ADDU, 5'd11, 5'd0, 5'd12, make_imm(16'h0000));    // old r11
        step(1'b1, `LUI, 5'd0, 5'd0, 5'd13, make_imm(16'h8000));
        step(1'b1, `SUB, 5'd13, 5'd10, 5'd14, make_imm(16'h0000));
        step(1'b1, `ADDU, 5'd14, 5'd11, 5'd15, make_imm(16'h0000));   // old r14 and r11

        test_name = "logic";
        op_pool = {`AND, `OR, `XOR, `NOR, `ANDI, `ORI, `XORI, `LUI};
        run_random(N_RAND, 1'b0);

        test_name = "shift";
        op_pool = {`SLL, `SRL, `SRA, `SLLV, `SRLV, `SRAV};
        run_random(N_RAND, 1'b0);

        test_name = "compare";
        op_pool = {`SLT, `SLTI, `SLTU, `SLTIU};
        run_random(N_RAND, 1'b0);
        step(1'b1, `LUI, 5'd0, 5'd0, 5'd1, make_imm(16'h8000));
        step(1'b1, `ORI, 5'd0, 5'd0, 5'd2, make_imm(16'h0001));
        step(1'b1, `SLT, 5'd1, 5'd2, 5'd3, make_imm(16'h0000));
        step(1'b1, `SLTU, 5'd1, 5'd2, 5'd4, make_imm(16'h0000));
        step(1'b1, `SLTI, 5'd1, 5'd0, 5'd5, make_imm(16'h0001));
        step(1'b1, `SLTIU, 5'd1, 5'd0, 5'd6, make_imm(16'hffff));
        step(1'b1, `SLTI, 5'd2, 5'd0, 5'd7, make_imm(16'hffff));

        test_name = "forwarding";
        op_pool = {`ADD, `ADDI, `ADDU, `SUBU, `AND, `ORI, `XOR, `SLL, `SRAV, `SLT, `LUI};
        run_random(N_CHAIN, 1'b1);

        test_name = "special";
        step(1'b1, `ADDIU, 5'd3, 5'd0, 5'd0, make_imm(16'h1234));     // tag 0 write dropped
        step(1'b1, `ADDU, 5'd0, 5'd0, 5'd8, make_imm(16'h0000));
        step(1'b1, `OR, 5'd0, 5'd0, 5'd8, make_imm(16'h0000));        // entry 0 from the regfile
        step(1'b1, `NOP, 5'd4, 5'd5, 5'd9, make_imm(16'h0000));
        step(1'b1, 6'h05, 5'd4, 5'd5, 5'd9, make_imm(16'h0000));      // illegal
        step(1'b1, 6'h3f, 5'd4, 5'd5, 5'd16, make_imm(16'hffff));
        step(1'b1, `ADDU, 5'd9, 5'd16, 5'd17, make_imm(16'h0000));
        repeat (2) idle();

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/simple_alu_lane_top.sv ====
//////////////////////////////////////////////////////////////////////
// simple_alu_lane_top: integer execute lane
// connects the pipeline registers, register file and ALU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module simple_alu_lane_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n_i,
    input  wire logic                          issue_valid_i,
    input  wire logic [`SIZE_OPCODE_I-1:0]     opcode_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] src1_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] src2_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] dest_i,
    input  wire alu_pkg::immd_t                immd_i,
    output logic                               wb_valid_o,
    output logic      [`SIZE_PHYSICAL_LOG-1:0] wb_dest_o,
    output logic      [`SIZE_DATA-1:0]         wb_result_o,
    output logic      [`EXECUTION_FLAGS-1:0]   wb_flags_o
);

    logic [`SIZE_PHYSICAL_LOG-1:0] rd_tag1;
    logic [`SIZE_PHYSICAL_LOG-1:0] rd_tag2;
    logic [`SIZE_DATA-1:0]         rd_data1;
    logic [`SIZE_DATA-1:0]         rd_data2;
    logic                          wr_en;
    logic [`SIZE_DATA-1:0]         alu_data1;
    logic [`SIZE_DATA-1:0]         alu_data2;
    logic [`SIZE_OPCODE_I-1:0]     alu_opcode;
    alu_pkg::immd_t                alu_immd;
    logic [`SIZE_DATA-1:0]         alu_result;
    logic [`EXECUTION_FLAGS-1:0]   alu_flags;

    exec_pipeline pipe_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .opcode_i      (opcode_i),
        .src1_i        (src1_i),
        .src2_i        (src2_i),
        .dest_i        (dest_i),
        .immd_i        (immd_i),
        .rd_tag1_o     (rd_tag1),
        .rd_tag2_o     (rd_tag2),
        .rd_data1_i    (rd_data1),
        .rd_data2_i    (rd_data2),
        .wr_en_o       (wr_en),
        .alu_data1_o   (alu_data1),
        .alu_data2_o   (alu_data2),
        .alu_opcode_o  (alu_opcode),
        .alu_immd_o    (alu_immd),
        .alu_result_i  (alu_result),
        .alu_flags_i   (alu_flags),
        .wb_valid_o    (wb_valid_o),
        .wb_dest_o     (wb_dest_o),
        .wb_result_o   (wb_result_o),
        .wb_flags_o    (wb_flags_o)
    );

    // written from the writeback register
    phys_regfile regfile_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_tag1_i  (rd_tag1),
        .rd_tag2_i  (rd_tag2),
        .rd_data1_o (rd_data1),
        .rd_data2_o (rd_data2),
        .wr_en_i    (wr_en),
        .wr_tag_i   (wb_dest_o),
        .wr_data_i  (wb_result_o)
    );

    simple_alu alu_i (
        .data1_i  (alu_data1),
        .data2_i  (alu_data2),
        .immd_i   (alu_immd),
        .opcode_i (alu_opcode),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

endmodule

`default_nettype wire

// ==== source/exec_pipeline.sv ====
//////////////////////////////////////////////////////////////////////
// exec_pipeline: issue register, operand forwarding and
// writeback register wrapped around the simple ALU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module exec_pipeline (
    input  wire logic                          clk,
    input  wire logic                          rst_n_i,
    // issue
    input  wire logic                          issue_valid_i,
    input  wire logic [`SIZE_OPCODE_I-1:0]     opcode_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] src1_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] src2_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] dest_i,
    input  wire alu_pkg::immd_t                immd_i,
    // register file
    output logic      [`SIZE_PHYSICAL_LOG-1:0] rd_tag1_o,
    output logic      [`SIZE_PHYSICAL_LOG-1:0] rd_tag2_o,
    input  wire logic [`SIZE_DATA-1:0]         rd_data1_i,
    input  wire logic [`SIZE_DATA-1:0]         rd_data2_i,
    output logic                               wr_en_o,
    // ALU
    output logic      [`SIZE_DATA-1:0]         alu_data1_o,
    output logic      [`SIZE_DATA-1:0]         alu_data2_o,
    output logic      [`SIZE_OPCODE_I-1:0]     alu_opcode_o,
    output alu_pkg::immd_t                     alu_immd_o,
    input  wire logic [`SIZE_DATA-1:0]         alu_result_i,
    input  wire logic [`EXECUTION_FLAGS-1:0]   alu_flags_i,
    // writeback
    output logic                               wb_valid_o,
    output logic      [`SIZE_PHYSICAL_LOG-1:0] wb_dest_o,
    output logic      [`SIZE_DATA-1:0]         wb_result_o,
    output logic      [`EXECUTION_FLAGS-1:0]   wb_flags_o
);

    logic                          iss_valid;
    logic [`SIZE_PHYSICAL_LOG-1:0] iss_src1;
    logic [`SIZE_PHYSICAL_LOG-1:0] iss_src2;
    logic [`SIZE_PHYSICAL_LOG-1:0] iss_dest;
    logic                          fwd1;
    logic                          fwd2;

    //////////////////////////////////////////////////////////////////////
    // issue register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_opcode_o <= opcode_i;
        iss_src1     <= src1_i;
        iss_src2     <= src2_i;
        iss_dest     <= dest_i;
        alu_immd_o   <= immd_i;
    end

    assign rd_tag1_o = iss_src1;
    assign rd_tag2_o = iss_src2;

    //////////////////////////////////////////////////////////////////////
    // forwarding from the writeback stage
    //////////////////////////////////////////////////////////////////////
    assign wr_en_o = wb_valid_o & wb_flags_o[`FLAG_WRITE_BIT];     // regfile write strobe

    assign fwd1 = wr_en_o && (wb_dest_o == iss_src1) && (iss_src1 != '0);
    assign fwd2 = wr_en_o && (wb_dest_o == iss_src2) && (iss_src2 != '0);

    assign alu_data1_o = fwd1 ? wb_result_o : rd_data1_i;
    assign alu_data2_o = fwd2 ? wb_result_o : rd_data2_i;

    //////////////////////////////////////////////////////////////////////
    // writeback register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_flags_o <= '0;
        end else begin
            wb_valid_o <= iss_valid;
            wb_flags_o <= alu_flags_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest_o   <= iss_dest;
        wb_result_o <= alu_result_i;
    end

endmodule

`default_nettype wire

// ==== source/phys_regfile.sv ====
//////////////////////////////////////////////////////////////////////
// phys_regfile: 32-entry physical register file
// two combinational read ports, one synchronous write port,
// tag 0 is never written and so always reads zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module phys_regfile (
    input  wire logic                          clk,
    input  wire logic                          rst_n_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] rd_tag1_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] rd_tag2_i,
    output logic      [`SIZE_DATA-1:0]         rd_data1_o,
    output logic      [`SIZE_DATA-1:0]         rd_data2_o,
    input  wire logic                          wr_en_i,
    input  wire logic [`SIZE_PHYSICAL_LOG-1:0] wr_tag_i,
    input  wire logic [`SIZE_DATA-1:0]         wr_data_i
);

    logic [`SIZE_DATA-1:0] regs [`PHYS_REGS];

    // old value is returned on a same-cycle write, forwarding covers it
    assign rd_data1_o = regs[rd_tag1_i];
    assign rd_data2_o = regs[rd_tag2_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_tag_i != '0)) begin    // tag 0 stays zero
            regs[wr_tag_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/simple_alu.sv ====
//////////////////////////////////////////////////////////////////////
// simple_alu: combinational integer ALU of the execute lane
// result plus execution flags for add/sub, logic, shifts,
// compares and LUI; illegal opcodes give zero result and flags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module simple_alu (
    input  wire logic [`SIZE_DATA-1:0]       data1_i,
    input  wire logic [`SIZE_DATA-1:0]       data2_i,
    input  wire alu_pkg::immd_t              immd_i,
    input  wire logic [`SIZE_OPCODE_I-1:0]   opcode_i,
    output logic      [`SIZE_DATA-1:0]       result_o,
    output logic      [`EXECUTION_FLAGS-1:0] flags_o
);

    localparam int MSB = `SIZE_DATA - 1;
    localparam int EXT = `SIZE_DATA - `SIZE_IMMEDIATE;

    logic [`SIZE_DATA-1:0] sign_ext_immd;
    logic [`SIZE_DATA-1:0] zero_ext_immd;

    assign sign_ext_immd = {{EXT{immd_i.imm[`SIZE_IMMEDIATE-1]}}, immd_i.imm};
    assign zero_ext_immd = {{EXT{1'b0}}, immd_i.imm};

    //////////////////////////////////////////////////////////////////////
    // operation select
    //////////////////////////////////////////////////////////////////////
    always_comb begin : alu_operation
        logic legal;        // opcode is one of the kept operations
        logic writes;       // operation produces a register value
        logic ovf;          // true signed overflow

        legal    = 1'b1;
        writes   = 1'b1;
        ovf      = 1'b0;
        result_o = '0;

        case (opcode_i)
            `ADD: begin
                result_o = data1_i + data2_i;
                ovf      = (data1_i[MSB] == data2_i[MSB]) && (result_o[MSB] != data1_i[MSB]);
            end
            `ADDI: begin
                result_o = data1_i + sign_ext_immd;
                ovf      = (data1_i[MSB] == sign_ext_immd[MSB]) &&
                           (result_o[MSB] != data1_i[MSB]);
            end
            `ADDU: begin
                result_o = data1_i + data2_i;
            end
            `ADDIU: begin
                result_o = data1_i + sign_ext_immd;
            end
            `SUB: begin
                result_o = data1_i - data2_i;
                ovf      = (data1_i[MSB] != data2_i[MSB]) && (result_o[MSB] != data1_i[MSB]);
            end
            `SUBU: begin
                result_o = data1_i - data2_i;
            end
            `AND: begin
                result_o = data1_i & data2_i;
            end
            `ANDI: begin
                result_o = data1_i & zero_ext_immd;
            end
            `OR: begin
                result_o = data1_i | data2_i;
            end
            `ORI: begin
                result_o = data1_i | zero_ext_immd;
            end
            `XOR: begin
                result_o = data1_i ^ data2_i;
            end
            `XORI: begin
                result_o = data1_i ^ zero_ext_immd;
            end
            `NOR: begin
                result_o = ~(data1_i | data2_i);
            end
            // constant shifts take the amount from the shamt field
            `SLL: begin
                result_o = data1_i << immd_i.rfmt.shamt;
            end
            `SRL: begin
                result_o = data1_i >> immd_i.rfmt.shamt;
            end
            `SRA: begin
                result_o = $signed(data1_i) >>> immd_i.rfmt.shamt;
            end
            // variable shifts move data2 by the low bits of data1
            `SLLV: begin
                result_o = data2_i << data1_i[`SIZE_SHAMT-1:0];
            end
            `SRLV: begin
                result_o = data2_i >> data1_i[`SIZE_SHAMT-1:0];
            end
            `SRAV: begin
                result_o = $signed(data2_i) >>> data1_i[`SIZE_SHAMT-1:0];
            end
            `SLT: begin
                result_o = {{MSB{1'b0}}, ($signed(data1_i) < $signed(data2_i))};
            end
            `SLTI: begin
                result_o = {{MSB{1'b0}}, ($signed(data1_i) < $signed(sign_ext_immd))};
            end
            `SLTU: begin
                result_o = {{MSB{1'b0}}, (data1_i < data2_i)};
            end
            `SLTIU: begin
                result_o = {{MSB{1'b0}}, (data1_i < zero_ext_immd)};
            end
            `LUI: begin
                result_o = {immd_i.imm, {`SIZE_IMMEDIATE{1'b0}}};
            end
            `NOP: begin
                writes = 1'b0;                          // executed only
            end
            default: begin
                legal  = 1'b0;
                writes = 1'b0;
            end
        endcase

        //////////////////////////////////////////////////////////////////////
        // execution flags
        //////////////////////////////////////////////////////////////////////
        flags_o                       = '0;
        flags_o[`FLAG_EXECUTED_BIT]   = legal;
        flags_o[`FLAG_EXCEPTION_BIT]  = ovf;
        flags_o[`FLAG_WRITE_BIT]      = writes & ~ovf;  // overflow suppresses the write
        flags_o[`FLAG_MISPREDICT_BIT] = 1'b0;
    end

endmodule

`default_nettype wire

// ==== source/alu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// types shared by the execute lane and its testbench
// immd_t, the immediate field seen either raw or in register format
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

    // register-format layout, shamt feeds the constant shifts
    typedef union packed {
        logic [`SIZE_IMMEDIATE-1:0] imm;        // raw 16-bit immediate
        struct packed {
            logic [`SIZE_RFMT_RD-1:0] rd;       // bits 15:11
            logic [`SIZE_SHAMT-1:0]   shamt;    // bits 10:6
            logic [`SIZE_FUNCT-1:0]   funct;    // bits 5:0
        } rfmt;
    } immd_t;

endpackage

`default_nettype wire

// ==== source/alu_consts.svh ====
//////////////////////////////////////////////////////////////////////
// widths, register count and flag bit positions of the execute lane
// opcode codes for every operation the simple ALU accepts
//////////////////////////////////////////////////////////////////////

`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define SIZE_DATA           32      // data path width
`define SIZE_IMMEDIATE      16      // immediate field of an issued instruction
`define SIZE_OPCODE_I       6
`define EXECUTION_FLAGS     6       // flag word width

`define PHYS_REGS           32      // physical register count
`define SIZE_PHYSICAL_LOG   5       // register tag width

// register-format view of the immediate field
`define SIZE_RFMT_RD        5
`define SIZE_SHAMT          5
`define SIZE_FUNCT          6

//////////////////////////////////////////////////////////////////////
// flag word bit positions, bits 5 and 3 stay zero
//////////////////////////////////////////////////////////////////////
`define FLAG_WRITE_BIT      4       // destination is written
`define FLAG_EXECUTED_BIT   2
`define FLAG_EXCEPTION_BIT  1       // signed overflow
`define FLAG_MISPREDICT_BIT 0       // never set by this unit

//////////////////////////////////////////////////////////////////////
// opcode codes, any code not listed is illegal
//////////////////////////////////////////////////////////////////////
`define NOP                 6'h00
`define SLL                 6'h01
`define SRL                 6'h02
`define SRA                 6'h03
`define SLLV                6'h04
`define SRLV                6'h06
`define SRAV                6'h07
`define ADDI                6'h08   // sign-extended immediate
`define ADDIU               6'h09
`define SLTI                6'h0a
`define SLTIU               6'h0b   // zero-extended immediate
`define ANDI                6'h0c
`define ORI                 6'h0d
`define XORI                6'h0e
`define LUI                 6'h0f
`define ADD                 6'h20
`define ADDU                6'h21
`define SUB                 6'h22
`define SUBU                6'h23
`define AND                 6'h24
`define OR                  6'h25
`define XOR                 6'h26
`define NOR                 6'h27
`define SLT                 6'h2a
`define SLTU                6'h2b

`endif
